/* Makefile */
SRCS := $(shell cat src.f)

.PHONY: run clean

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top > sim.log 2>&1; cat sim.log
	grep -q "^Test OK$$" sim.log

obj_dir/Vtb_top: src.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_top -f src.f -o Vtb_top

clean:
	rm -rf obj_dir sim.log

/* src.f */
src/cpu_pkg.sv
src/core_ifs.sv
src/pc_counter.sv
src/insn_sequencer.sv
src/reg_bank.sv
src/alu.sv
src/cpu_core.sv
testbench/prog_mem.sv
testbench/tb_top.sv

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic                       clk,
    input  logic                       rst,
    alu_ctrl_if.alu                    alu_c,
    output logic [2:0]                 rd_a_sel,
    output logic [2:0]                 rd_b_sel,
    input  logic [cpu_pkg::DATA_W-1:0] rd_a,
    input  logic [cpu_pkg::DATA_W-1:0] rd_b,
    output logic                       wr_en,
    output logic [2:0]                 wr_sel,
    output cpu_pkg::size_e             wr_size,
    output logic [cpu_pkg::DATA_W-1:0] wr_data,
    output logic [7:0]                 flags
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] opb;
    logic [DATA_W-1:0] mask;
    logic [DATA_W-1:0] topm;     // Single bit at the operand's sign position
    logic [DATA_W:0]   ext;      // Result with carry room
    logic              cin;
    logic              is_sub;
    logic              arith;
    logic              a_top;
    logic              b_top;
    logic              r_top;
    logic              carry;
    logic              ovf;
    logic [7:0]        nx_flags;

    assign rd_a_sel = alu_c.dst;
    assign rd_b_sel = alu_c.src;
    assign opb      = alu_c.use_imm ? alu_c.imm : rd_b;

    always_comb begin
        case (alu_c.size)
            SZ_BYTE: mask = 32'h0000_00ff;
            SZ_WORD: mask = 32'h0000_ffff;
            default: mask = 32'hffff_ffff;
        endcase
    end

    assign topm   = mask ^ (mask >> 1);
    assign cin    = (alu_c.op inside {ALU_ADC, ALU_SBC}) && flags[FLAG_C];
    assign is_sub = alu_c.op inside {ALU_SUB, ALU_SBC, ALU_CP};
    assign arith  = is_sub || (alu_c.op inside {ALU_ADD, ALU_ADC});

    always_comb begin
        case (alu_c.op)
            ALU_ADD, ALU_ADC: ext = {1'b0, rd_a & mask} + {1'b0, opb & mask}
                                    + {{DATA_W{1'b0}}, cin};
            ALU_SUB, ALU_SBC, ALU_CP: ext = {1'b0, rd_a & mask} - {1'b0, opb & mask}
                                            - {{DATA_W{1'b0}}, cin};
            ALU_AND: ext = {1'b0, rd_a & opb};
            ALU_XOR: ext = {1'b0, rd_a ^ opb};
            ALU_OR:  ext = {1'b0, rd_a | opb};
            ALU_MOVE: ext = {1'b0, opb};
            default: ext = {1'b0, rd_a};
        endcase
    end

    assign a_top = |(rd_a & topm);
    assign b_top = |(opb & topm);
    assign r_top = |(ext[DATA_W-1:0] & topm);
    assign carry = |(ext & {topm, 1'b0});   // Borrow on subtraction
    assign ovf   = (is_sub ? (a_top ^ b_top) : ~(a_top ^ b_top)) & (r_top ^ a_top);

    always_comb begin
        nx_flags = flags;
        case (alu_c.op)
            ALU_NOP: ;
            ALU_RCF: nx_flags[FLAG_C] = 1'b0;
            ALU_SCF: nx_flags[FLAG_C] = 1'b1;
            ALU_CCF: nx_flags[FLAG_C] = ~flags[FLAG_C];
            ALU_ZCF: nx_flags[FLAG_C] = ~flags[FLAG_Z];
            default: begin
                nx_flags[FLAG_S] = r_top;
                nx_flags[FLAG_Z] = (ext[DATA_W-1:0] & mask) == '0;
                nx_flags[FLAG_V] = arith & ovf;
                nx_flags[FLAG_C] = arith & carry;
            end
        endcase
    end

    assign wr_en   = alu_c.go && (alu_c.op inside {[ALU_MOVE:ALU_OR]});
    assign wr_sel  = alu_c.dst;
    assign wr_size = alu_c.size;
    assign wr_data = ext[DATA_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= '0;
        end else if (alu_c.go) begin
            flags <= nx_flags;
        end
    end

endmodule

`default_nettype wire

/* src/core_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

interface alu_ctrl_if;
    import cpu_pkg::*;

    alu_op_e           op;
    size_e             size;
    logic [2:0]        dst;
    logic [2:0]        src;
    logic              use_imm;    // Second operand from imm instead of src
    logic [DATA_W-1:0] imm;
    logic              go;         // One-cycle command strobe

    modport seq (output op, size, dst, src, use_imm, imm, go);
    modport alu (input op, size, dst, src, use_imm, imm, go);
endinterface

interface pc_ctrl_if;
    import cpu_pkg::*;

    logic [2:0]      step;         // Bytes consumed
    logic            step_en;
    logic            rel_en;
    logic [PC_W-1:0] rel_off;      // Already sign-extended

    modport seq (output step, step_en, rel_en, rel_off);
    modport cnt (input step, step_en, rel_en, rel_off);
endinterface

`default_nettype wire

/* src/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  logic                       clk,
    input  logic                       rst,
    output logic                       op_req,
    output logic [cpu_pkg::PC_W-1:0]   op_addr,
    input  logic                       op_ack,
    input  logic [cpu_pkg::DATA_W-1:0] op_data,
    output logic                       insn_done,
    output logic [7:0]                 flags,
    input  logic [2:0]                 reg_rd_sel,
    output logic [cpu_pkg::DATA_W-1:0] reg_rd_data
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] rd_a;
    logic [DATA_W-1:0] rd_b;
    logic [2:0]        rd_a_sel;
    logic [2:0]        rd_b_sel;
    logic              wr_en;
    logic [2:0]        wr_sel;
    size_e             wr_size;
    logic [DATA_W-1:0] wr_data;

    alu_ctrl_if alu_c ();
    pc_ctrl_if  pc_c ();

    insn_sequencer u_seq (
        .clk       (clk),
        .rst       (rst),
        .op_req    (op_req),
        .op_ack    (op_ack),
        .op_data   (op_data),
        .flags     (flags),
        .insn_done (insn_done),
        .alu_c     (alu_c.seq),
        .pc_c      (pc_c.seq)
    );

    pc_counter u_pc (
        .clk  (clk),
        .rst  (rst),
        .pc   (op_addr),        // Fetch address is the pc itself
        .pc_c (pc_c.cnt)
    );

    reg_bank u_regs (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_sel     (wr_sel),
        .wr_size    (wr_size),
        .wr_data    (wr_data),
        .rd_a_sel   (rd_a_sel),
        .rd_b_sel   (rd_b_sel),
        .rd_dbg_sel (reg_rd_sel),
        .rd_a       (rd_a),
        .rd_b       (rd_b),
        .rd_dbg     (reg_rd_data)
    );

    alu u_alu (
        .clk      (clk),
        .rst      (rst),
        .alu_c    (alu_c.alu),
        .rd_a_sel (rd_a_sel),
        .rd_b_sel (rd_b_sel),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_size  (wr_size),
        .wr_data  (wr_data),
        .flags    (flags)
    );

endmodule

`default_nettype wire

/* src/cpu_pkg.sv */
package cpu_pkg;

    localparam int PC_W   = 24;
    localparam int DATA_W = 32;

    // Positions in the 8-bit flag word, H and N read as zero
    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_V = 2;
    localparam int FLAG_C = 0;

    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_WORD,
        SZ_LONG
    } size_e;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_MOVE,
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_XOR,
        ALU_OR,
        ALU_CP,
        ALU_RCF,
        ALU_SCF,
        ALU_CCF,
        ALU_ZCF
    } alu_op_e;

    localparam logic [7:0] OPC_NOP = 8'h00;
    localparam logic [7:0] OPC_RCF = 8'h10;
    localparam logic [7:0] OPC_SCF = 8'h11;
    localparam logic [7:0] OPC_CCF = 8'h12;
    localparam logic [7:0] OPC_ZCF = 8'h13;
    localparam logic [7:0] OPC_LDB = 8'h20;    // LD R,# with R in bits 2:0
    localparam logic [7:0] OPC_LDW = 8'h30;
    localparam logic [7:0] OPC_LDL = 8'h40;
    localparam logic [7:0] OPC_JR  = 8'h60;    // Condition in bits 3:0
    localparam logic [7:0] OPC_JRL = 8'h70;
    localparam logic [7:0] OPC_RRB = 8'hC8;    // Prefix of r, then 1ccc_0RRR
    localparam logic [7:0] OPC_RRW = 8'hD8;
    localparam logic [7:0] OPC_RRL = 8'hE8;

    typedef struct packed {
        logic [23:0] tail;   // Bytes 3..1, immediates and displacements
        logic [3:0]  grp;    // Group nibble, size in bits 1:0 for RR
        logic [3:0]  cond;   // Condition, or mode bit and register
    } op_fields_t;

    // Byte 0 sits at the fetch address
    typedef union packed {
        logic [3:0][7:0] bytes;
        op_fields_t      f;
    } op_window_t;

endpackage

/* src/insn_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_sequencer (
    input  logic                clk,
    input  logic                rst,
    output logic                op_req,
    input  logic                op_ack,
    input  cpu_pkg::op_window_t op_data,
    input  logic [7:0]          flags,
    output logic                insn_done,
    alu_ctrl_if.seq             alu_c,
    pc_ctrl_if.seq              pc_c
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {REQ, RELEASE, EXEC, FILL_IMM} state_e;

    state_e     state;
    state_e     nx_state;
    op_window_t win;              // Latched opcode window
    logic [7:0] imm_hi;           // Byte 0 of the refetch for a long LD
    logic       fill_pend;
    logic       fill_set;
    logic       jp_ok;
    logic [7:0] op0;
    logic [7:0] op1;
    logic [7:0] op_r;             // Opcode with register field cleared
    logic [7:0] op_c;             // Opcode with condition field cleared

    assign op0    = win.bytes[0];
    assign op1    = win.bytes[1];
    assign op_r   = {op0[7:3], 3'b000};
    assign op_c   = {op0[7:4], 4'h0};
    assign op_req = state == REQ;

    // Codes 8 to 15 are the complements of 0 to 7
    always_comb begin
        case (win.f.cond[2:0])
            3'd0: jp_ok = 1'b0;
            3'd1: jp_ok = flags[FLAG_S] ^ flags[FLAG_V];
            3'd2: jp_ok = flags[FLAG_Z] | (flags[FLAG_S] ^ flags[FLAG_V]);
            3'd3: jp_ok = flags[FLAG_Z] | flags[FLAG_C];
            3'd4: jp_ok = flags[FLAG_V];
            3'd5: jp_ok = flags[FLAG_S];
            3'd6: jp_ok = flags[FLAG_Z];
            default: jp_ok = flags[FLAG_C];
        endcase
        if (win.f.cond[3]) begin
            jp_ok = ~jp_ok;
        end
    end

    always_comb begin
        nx_state      = state;
        insn_done     = 1'b0;
        fill_set      = 1'b0;
        alu_c.op      = ALU_NOP;
        alu_c.size    = SZ_LONG;
        alu_c.dst     = op0[2:0];
        alu_c.src     = op0[2:0];
        alu_c.use_imm = 1'b0;
        alu_c.imm     = {8'h00, win.f.tail};
        alu_c.go      = 1'b0;
        pc_c.step     = 3'd1;      // Also skips unknown opcodes
        pc_c.step_en  = 1'b0;
        pc_c.rel_en   = 1'b0;
        pc_c.rel_off  = {{(PC_W-8){op1[7]}}, op1};
        case (state)
            RELEASE: if (!op_ack) nx_state = REQ;
            REQ: if (op_ack) nx_state = fill_pend ? FILL_IMM : EXEC;
            EXEC: begin
                nx_state     = op_ack ? RELEASE : REQ;
                alu_c.go     = 1'b1;
                pc_c.step_en = 1'b1;
                insn_done    = 1'b1;
                if (op0 == OPC_NOP) begin
                    pc_c.step = 3'd1;
                end else if (op0 inside {OPC_RCF, OPC_SCF, OPC_CCF, OPC_ZCF}) begin
                    case (op0)
                        OPC_RCF: alu_c.op = ALU_RCF;
                        OPC_SCF: alu_c.op = ALU_SCF;
                        OPC_CCF: alu_c.op = ALU_CCF;
                        default: alu_c.op = ALU_ZCF;
                    endcase
                end else if (op_r inside {OPC_LDB, OPC_LDW, OPC_LDL}) begin
                    alu_c.op      = ALU_MOVE;
                    alu_c.use_imm = 1'b1;
                    if (op_r == OPC_LDB) begin
                        alu_c.size = SZ_BYTE;
                        pc_c.step  = 3'd2;
                    end else if (op_r == OPC_LDW) begin
                        alu_c.size = SZ_WORD;
                        pc_c.step  = 3'd3;
                    end else begin
                        alu_c.go  = 1'b0;   // Top byte still missing
                        insn_done = 1'b0;
                        fill_set  = 1'b1;
                        pc_c.step = 3'd4;
                    end
                end else if (op_c == OPC_JR || op_c == OPC_JRL) begin
                    pc_c.rel_en = jp_ok;
                    if (op_c == OPC_JRL) begin
                        pc_c.step    = 3'd3;
                        pc_c.rel_off = {{(PC_W-16){win.f.tail[15]}}, win.f.tail[15:0]};
                    end else begin
                        pc_c.step = 3'd2;
                    end
                end else if (op_r inside {OPC_RRB, OPC_RRW, OPC_RRL} && op1[7] && !op1[3]) begin
                    alu_c.size = size_e'(win.f.grp[1:0]);
                    alu_c.dst  = op1[2:0];  // R from second byte, r from prefix
                    pc_c.step  = 3'd2;
                    case (op1[6:4])
                        3'd0: alu_c.op = ALU_ADD;
                        3'd1: alu_c.op = ALU_ADC;
                        3'd2: alu_c.op = ALU_SUB;
                        3'd3: alu_c.op = ALU_SBC;
                        3'd4: alu_c.op = ALU_AND;
                        3'd5: alu_c.op = ALU_XOR;
                        3'd6: alu_c.op = ALU_OR;
                        default: alu_c.op = ALU_CP;
                    endcase
                end
            end
            FILL_IMM: begin
                nx_state      = op_ack ? RELEASE : REQ;
                alu_c.op      = ALU_MOVE;
                alu_c.use_imm = 1'b1;
                alu_c.imm     = {imm_hi, win.f.tail};
                alu_c.go      = 1'b1;
                pc_c.step_en  = 1'b1;
                insn_done     = 1'b1;
            end
            default: nx_state = RELEASE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= RELEASE;   // Raises op_req on the first clock
            fill_pend <= 1'b0;
        end else begin
            state <= nx_state;
            if (fill_set) begin
                fill_pend <= 1'b1;
            end else if (state == FILL_IMM) begin
                fill_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == REQ && op_ack) begin
            if (fill_pend) begin
                imm_hi <= op_data.bytes[0];  // Keep the first window
            end else begin
                win <= op_data;
            end
        end
    end

endmodule

`default_nettype wire

/* src/pc_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_counter (
    input  logic                     clk,
    input  logic                     rst,
    output logic [cpu_pkg::PC_W-1:0] pc,
    pc_ctrl_if.cnt                   pc_c
);
    import cpu_pkg::*;

    logic [PC_W-1:0] nx_pc;

    // Step and displacement land in a single update
    always_comb begin
        nx_pc = pc + {{(PC_W-3){1'b0}}, pc_c.step};
        if (pc_c.rel_en) begin
            nx_pc = nx_pc + pc_c.rel_off;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (pc_c.step_en) begin
            pc <= nx_pc;
        end
    end

endmodule

`default_nettype wire

/* src/reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wr_en,
    input  logic [2:0]                 wr_sel,
    input  cpu_pkg::size_e             wr_size,
    input  logic [cpu_pkg::DATA_W-1:0] wr_data,
    input  logic [2:0]                 rd_a_sel,
    input  logic [2:0]                 rd_b_sel,
    input  logic [2:0]                 rd_dbg_sel,
    output logic [cpu_pkg::DATA_W-1:0] rd_a,
    output logic [cpu_pkg::DATA_W-1:0] rd_b,
    output logic [cpu_pkg::DATA_W-1:0] rd_dbg
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] regs [8];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            case (wr_size)
                SZ_BYTE: regs[wr_sel][7:0]  <= wr_data[7:0];   // Upper bits kept
                SZ_WORD: regs[wr_sel][15:0] <= wr_data[15:0];
                default: regs[wr_sel]       <= wr_data;
            endcase
        end
    end

    assign rd_a   = regs[rd_a_sel];
    assign rd_b   = regs[rd_b_sel];
    assign rd_dbg = regs[rd_dbg_sel];

endmodule

`default_nettype wire

/* testbench/prog_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module prog_mem (
    input  logic        clk,
    input  logic        rst,
    input  logic        op_req,
    input  logic [23:0] op_addr,
    output logic        op_ack,
    output logic [31:0] op_data
);

    logic [7:0] mem [1024];    // Written by the testbench before reset ends

    initial begin : handshake_proc
        logic       req_s;
        logic       ack_s;
        logic [9:0] a;
        int         lat;
        op_ack  = 1'b0;
        op_data = '0;
        lat     = 0;
        forever begin
            @(posedge clk);
            req_s = op_req;     // Values from before the edge
            ack_s = op_ack;
            #1;
            a = op_addr[9:0];
            if (rst) begin
                op_ack = 1'b0;
                lat    = $urandom % 6;
            end else if (req_s && !ack_s) begin
                if (lat == 0) begin
                    op_data = {mem[10'(a + 10'd3)], mem[10'(a + 10'd2)],
                               mem[10'(a + 10'd1)], mem[a]};
                    op_ack  = 1'b1;
                end else begin
                    lat--;      // Random wait before ack
                end
            end else if (!req_s && ack_s) begin
                op_ack = 1'b0;
                lat    = $urandom % 6;
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import cpu_pkg::*;

    logic        clk;
    logic        rst;
    logic        op_req;
    logic        op_ack;
    logic [23:0] op_addr;
    logic [31:0] op_data;
    logic        insn_done;
    logic [7:0]  flags;
    logic [2:0]  reg_rd_sel;
    logic [31:0] reg_rd_data;

    logic [7:0]  prog [1024];
    int          plen;
    int          n_insn;
    int          limit;
    int          cycles;
    logic [31:0] mreg [8];     // Reference register file
    logic [7:0]  mflags;
    logic [23:0] mpc;
    logic [2:0]  dsel;
    logic        chk;
    logic [23:0] exp_pc;
    logic [7:0]  exp_flags;
    logic [31:0] exp_reg;
    int          res_errs;
    int          hs_errs;
    int          npass;
    int          nfail;
    int          seg_end [1:4];
    int          errs_prev;
    string       names [1:5];

    cpu_core DUT (
        .clk         (clk),
        .rst         (rst),
        .op_req      (op_req),
        .op_addr     (op_addr),
        .op_ack      (op_ack),
        .op_data     (op_data),
        .insn_done   (insn_done),
        .flags       (flags),
        .reg_rd_sel  (reg_rd_sel),
        .reg_rd_data (reg_rd_data)
    );

    prog_mem u_mem (
        .clk     (clk),
        .rst     (rst),
        .op_req  (op_req),
        .op_addr (op_addr),
        .op_ack  (op_ack),
        .op_data (op_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic put(input logic [7:0] b);
        prog[plen] = b;
        plen++;
    endtask

    task automatic put_op(input logic [7:0] b);
        put(b);
        n_insn++;
    endtask

    task automatic put_ld(input logic [1:0] sz, input logic [2:0] r, input logic [31:0] v);
        case (sz)
            2'd0: put(OPC_LDB | {5'b0, r});
            2'd1: put(OPC_LDW | {5'b0, r});
            default: put(OPC_LDL | {5'b0, r});
        endcase
        put(v[7:0]);
        if (sz != 2'd0) put(v[15:8]);
        if (sz == 2'd2) begin
            put(v[23:16]);
            put(v[31:24]);    // Lands in the second fetch
        end
        n_insn++;
    endtask

    task automatic put_rr(input logic [1:0] sz, input logic [2:0] op3,
                          input logic [2:0] dst, input logic [2:0] src);
        case (sz)
            2'd0: put(OPC_RRB | {5'b0, src});
            2'd1: put(OPC_RRW | {5'b0, src});
            default: put(OPC_RRL | {5'b0, src});
        endcase
        put({1'b1, op3, 1'b0, dst});
        n_insn++;
    endtask

    // Jump over d NOPs, which run only when the jump is not taken
    task automatic put_jr(input logic is_long, input logic [3:0] cc, input logic [7:0] d);
        put((is_long ? OPC_JRL : OPC_JR) | {4'b0, cc});
        put(d);
        if (is_long) put(8'h00);
        n_insn++;
        for (int i = 0; i < int'(d); i++) put_op(OPC_NOP);
    endtask

    function automatic logic cond_true(input logic [3:0] cc, input logic [7:0] f);
        logic s, z, v, c, r;
        s = f[FLAG_S];
        z = f[FLAG_Z];
        v = f[FLAG_V];
        c = f[FLAG_C];
        case (cc[2:0])
            3'd0: r = 1'b0;
            3'd1: r = s != v;                 // Signed less than
            3'd2: r = z || (s != v);
            3'd3: r = z || c;                 // Unsigned lower or same
            3'd4: r = v;
            3'd5: r = s;
            3'd6: r = z;
            default: r = c;
        endcase
        return cc[3] ? !r : r;
    endfunction

    task automatic step_model();
        logic [7:0]  b0, b1, b2, b3, b4;
        logic [63:0] a, b, res, mask;
        logic [23:0] len, off;
        logic        s, z, v, c, cin, wr;
        int          w;
        b0 = prog[mpc[9:0]];
        b1 = prog[10'(mpc[9:0] + 10'd1)];
        b2 = prog[10'(mpc[9:0] + 10'd2)];
        b3 = prog[10'(mpc[9:0] + 10'd3)];
        b4 = prog[10'(mpc[9:0] + 10'd4)];
        dsel = b0[2:0];
        len = 24'd1;
        off = 24'd0;
        w = 32;
        wr = 1'b0;
        res = '0;
        {s, z, v, c} = {mflags[FLAG_S], mflags[FLAG_Z], mflags[FLAG_V], mflags[FLAG_C]};
        if (b0 == OPC_RCF) c = 1'b0;
        else if (b0 == OPC_SCF) c = 1'b1;
        else if (b0 == OPC_CCF) c = !c;
        else if (b0 == OPC_ZCF) c = !z;
        else if (b0[7:3] inside {OPC_LDB[7:3], OPC_LDW[7:3], OPC_LDL[7:3]}) begin
            w = (b0[7:3] == OPC_LDB[7:3]) ? 8 : (b0[7:3] == OPC_LDW[7:3]) ? 16 : 32;
            len = (w == 8) ? 24'd2 : (w == 16) ? 24'd3 : 24'd5;
            res = {32'h0, b4, b3, b2, b1};
            wr = 1'b1;
            v = 1'b0;
            c = 1'b0;
        end else if (b0[7:4] == OPC_JR[7:4]) begin
            len = 24'd2;
            if (cond_true(b0[3:0], mflags)) off = {{16{b1[7]}}, b1};
        end else if (b0[7:4] == OPC_JRL[7:4]) begin
            len = 24'd3;
            if (cond_true(b0[3:0], mflags)) off = {{8{b2[7]}}, b2, b1};
        end else if (b0[7:3] inside {OPC_RRB[7:3], OPC_RRW[7:3], OPC_RRL[7:3]}) begin
            w = (b0[7:3] == OPC_RRB[7:3]) ? 8 : (b0[7:3] == OPC_RRW[7:3]) ? 16 : 32;
            len = 24'd2;
            dsel = b1[2:0];
            mask = (64'd1 << w) - 64'd1;
            a = {32'h0, mreg[dsel]} & mask;
            b = {32'h0, mreg[b0[2:0]]} & mask;
            cin = (b1[6:4] == 3'd1 || b1[6:4] == 3'd3) && mflags[FLAG_C];
            wr = b1[6:4] != 3'd7;    // CP only compares
            case (b1[6:4])
                3'd0, 3'd1: begin
                    res = a + b + {63'h0, cin};
                    c = res[w];
                    v = (a[w-1] == b[w-1]) && (res[w-1] != a[w-1]);
                end
                3'd4: res = a & b;
                3'd5: res = a ^ b;
                3'd6: res = a | b;
                default: begin
                    res = a - b - {63'h0, cin};
                    c = a < b + {63'h0, cin};
                    v = (a[w-1] != b[w-1]) && (res[w-1] != a[w-1]);
                end
            endcase
            if (b1[6:4] inside {3'd4, 3'd5, 3'd6}) {v, c} = 2'b00;
        end
        mask = (64'd1 << w) - 64'd1;
        if (len != 24'd1 && b0[7:5] != 3'b011) begin
            s = res[w-1];
            z = (res & mask) == 64'h0;
        end
        if (wr) mreg[dsel] = (mreg[dsel] & ~mask[31:0]) | (res[31:0] & mask[31:0]);
        mflags = {s, z, 3'b000, v, 1'b0, c};
        mpc = mpc + len + off;
    endtask

    always @(posedge clk) begin : model_proc
        logic done_s;
        done_s = insn_done;
        #2;
        chk = 1'b0;
        if (!rst && done_s) begin
            step_model();
            reg_rd_sel = dsel;
            exp_pc = mpc;
            exp_flags = mflags;
            exp_reg = mreg[dsel];
            chk = 1'b1;         // Checked on the next edge
        end
    end

    a_pc: assert property (@(posedge clk) disable iff (rst) chk |-> op_addr == exp_pc)
        else begin
            res_errs++;
            $display("MISMATCH %0t: pc %h, expected %h", $time, op_addr, exp_pc);
        end
    a_flags: assert property (@(posedge clk) disable iff (rst) chk |-> flags == exp_flags)
        else begin
            res_errs++;
            $display("MISMATCH %0t: flags %h, expected %h", $time, flags, exp_flags);
        end
    a_reg: assert property (@(posedge clk) disable iff (rst) chk |-> reg_rd_data == exp_reg)
        else begin
            res_errs++;
            $display("MISMATCH %0t: R%0d is %h, expected %h", $time, reg_rd_sel,
                     reg_rd_data, exp_reg);
        end
    a_req_fall: assert property (@(posedge clk) disable iff (rst)
                                 $fell(op_req) |-> $past(op_ack))
        else begin
            hs_errs++;
            $display("At %0t op_req fell before op_ack was seen high", $time);
        end
    a_req_rise: assert property (@(posedge clk) disable iff (rst)
                                 $rose(op_req) |-> !$past(op_ack))
        else begin
            hs_errs++;
            $display("At %0t op_req rose while op_ack was still high", $time);
        end
    a_addr: assert property (@(posedge clk) disable iff (rst)
                             op_req && $past(op_req) |-> op_addr == $past(op_addr))
        else begin
            hs_errs++;
            $display("At %0t op_addr moved during a fetch request", $time);
        end
    a_reset: assert property (@(posedge clk) rst || $fell(rst) |-> !op_req && !insn_done)
        else begin
            hs_errs++;
            $display("At %0t op_req or insn_done was high in or right after reset", $time);
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, the program did not complete", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(78));
        rst = 1'b1;
        reg_rd_sel = 3'd0;
        chk = 1'b0;
        {plen, n_insn, cycles, res_errs, hs_errs, npass, nfail} = '0;
        limit = 1000000;
        names = '{"LD sizes", "RR arithmetic", "carry flag ops", "JR and JRL", "handshake"};
        for (int i = 0; i < 1024; i++) prog[i] = OPC_NOP;
        for (int i = 0; i < 8; i++) mreg[i] = '0;
        mflags = '0;
        mpc = '0;
        put_ld(2'd2, 3'd3, 32'h1122_3344);
        put_ld(2'd0, 3'd3, 32'h0000_00a5);
        put_ld(2'd1, 3'd3, 32'h0000_beef);
        for (int i = 0; i < 8; i++) put_ld(2'd2, 3'(i), $urandom);
        put_ld(2'd0, 3'd4, 32'h0000_0080);
        seg_end[1] = plen;
        for (int i = 0; i < 24; i++) begin
            put_ld(2'd2, 3'd1, $urandom);
            put_ld(2'd2, 3'd2, $urandom);
            put_op((i % 2 == 1) ? OPC_SCF : OPC_RCF);
            put_rr(2'(i % 3), 3'(i % 8), 3'd1, 3'd2);
        end
        put_ld(2'd2, 3'd1, 32'h8000_0000);
        put_ld(2'd2, 3'd2, 32'h8000_0000);
        put_rr(2'd2, 3'd0, 3'd1, 3'd2);    // Zero, carry and overflow
        put_rr(2'd0, 3'd2, 3'd2, 3'd1);
        seg_end[2] = plen;
        put_ld(2'd0, 3'd7, 32'h0);
        put_op(OPC_SCF);
        put_op(OPC_ZCF);
        put_op(OPC_CCF);
        put_op(OPC_RCF);
        put_ld(2'd0, 3'd7, 32'h1);
        put_op(OPC_ZCF);
        put_op(OPC_CCF);
        seg_end[3] = plen;
        put_ld(2'd0, 3'd5, 32'h40);
        for (int j = 0; j < 32; j++) begin
            case (j % 4)
                0: put_ld(2'd0, 3'd7, 32'h0);
                1: put_ld(2'd0, 3'd7, 32'h80);
                2: begin
                    put_ld(2'd0, 3'd4, 32'h40);
                    put_rr(2'd0, 3'd0, 3'd4, 3'd5);    // Signed overflow
                end
                default: put_ld(2'd0, 3'd7, 32'h1);
            endcase
            if ((j / 4) % 2 == 1) put_op(OPC_SCF);
            put_jr(j >= 16, 4'(j % 16), (j >= 16) ? 8'd2 : 8'd1);
        end
        seg_end[4] = plen;
        limit = 40 * n_insn + 20;
        for (int i = 0; i < 1024; i++) u_mem.mem[i] = prog[i];
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;
        errs_prev = 0;
        for (int t = 1; t <= 4; t++) begin
            wait (int'(mpc) >= seg_end[t]);
            repeat (2) @(posedge clk);
            if (res_errs == errs_prev) npass++;
            else nfail++;
            $display("test %0d %s: %0d errors", t, names[t], res_errs - errs_prev);
            errs_prev = res_errs;
        end
        if (hs_errs == 0) npass++;
        else nfail++;
        $display("test 5 %s: %0d errors", names[5], hs_errs);
        $display("passed %0d, failed %0d", npass, nfail);
        if (nfail == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
